//--- Makefile
TOP = operandStageTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- rtl/coreCfgPkg.sv
`default_nettype none

package coreCfgPkg;

    // Back-end geometry
    localparam int numUops = 4;
    localparam int numWbs = 2;
    localparam int numZcFwds = 1;
    localparam int numPcReads = 2;

    localparam int numRegs = 64;
    localparam int regAddrBits = $clog2(numRegs);

    localparam int numFetchIds = 16;
    localparam int fetchOffBits = 3;

    typedef logic [$clog2(numFetchIds)-1:0] FetchId;
    typedef logic [fetchOffBits-1:0] FetchOff;

    typedef struct packed {
        logic predicted;
        logic taken;
    } BranchPredInfo;

    // One fetch block, PC in halfwords
    typedef struct packed {
        logic [30:0] pc;
        FetchOff branchPos;
        BranchPredInfo bpi;
    } PcFileEntry;

    typedef struct packed {
        logic valid;
        FetchId addr;
    } PcFileReadReq;

    typedef struct packed {
        logic valid;
        FetchId addr;
        PcFileEntry data;
    } PcFileWrite;

endpackage

`default_nettype wire

//--- rtl/operandLoad.sv
`timescale 1ns/1ps
`default_nettype none

module operandLoad (
    input wire logic clk,
    input wire logic rst,

    input var uopPkg::IS_UOp uops [coreCfgPkg::numUops],
    input var uopPkg::RES_UOp wbResults [coreCfgPkg::numWbs],

    input wire logic invalidate,
    input var uopPkg::SqN invalidateSqN,

    input wire logic [coreCfgPkg::numUops-1:0] stall,
    input var uopPkg::ZCForward zcFwds [coreCfgPkg::numZcFwds],

    output coreCfgPkg::PcFileReadReq pcRead [coreCfgPkg::numPcReads],
    input var coreCfgPkg::PcFileEntry pcReadData [coreCfgPkg::numPcReads],

    output logic [coreCfgPkg::regAddrBits-1:0] rfReadAddr [2*coreCfgPkg::numUops],
    input wire logic [31:0] rfReadData [2*coreCfgPkg::numUops],

    output uopPkg::EX_UOp exUops [coreCfgPkg::numUops]
);

    typedef struct packed {
        logic fromRf;
        logic [31:0] value;
    } Operand;

    function automatic logic isNewer(input uopPkg::SqN a, input uopPkg::SqN b);
        uopPkg::SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    // Constant tag, then bypass, then fall back to the register file
    function automatic Operand resolve(
        input uopPkg::Tag tag,
        input uopPkg::RES_UOp wbs [coreCfgPkg::numWbs],
        input uopPkg::ZCForward zcs [coreCfgPkg::numZcFwds]
    );
        Operand res;
        res.fromRf = 1'b0;
        res.value = '0;
        if (tag[6]) begin
            res.value = {{26{tag[5]}}, tag[5:0]};
        end else begin
            res.fromRf = 1'b1;
            for (int j = 0; j < coreCfgPkg::numWbs; j++) begin
                if (wbs[j].valid && wbs[j].tagDst == tag) begin
                    res.value = wbs[j].result;
                    res.fromRf = 1'b0;
                end
            end
            // Zero-cycle forward is the newest value
            for (int j = 0; j < coreCfgPkg::numZcFwds; j++) begin
                if (zcs[j].valid && zcs[j].tag == tag) begin
                    res.value = zcs[j].result;
                    res.fromRf = 1'b0;
                end
            end
        end
        return res;
    endfunction

    for (genvar i = 0; i < coreCfgPkg::numUops; i++) begin : gPort
        uopPkg::EX_UOp held;
        uopPkg::EX_UOp nextUop;
        logic [1:0] operandIsReg;
        logic [1:0] nextIsReg;
        logic pcFresh;
        logic accept;
        logic squashHeld;
        Operand opA;
        Operand opB;
        logic [31:0] pc;
        coreCfgPkg::FetchOff startOffs;
        coreCfgPkg::FetchOff predOffs;
        coreCfgPkg::BranchPredInfo bpi;

        assign accept = uops[i].valid && !stall[i]
            && !(invalidate && isNewer(uops[i].sqN, invalidateSqN));
        assign squashHeld = held.valid && invalidate && isNewer(held.sqN, invalidateSqN);

        assign opA = resolve(uops[i].tagA, wbResults, zcFwds);
        assign opB = resolve(uops[i].tagB, wbResults, zcFwds);

        assign rfReadAddr[i] = uops[i].tagA[coreCfgPkg::regAddrBits-1:0];

        // Integer ports own a PC-file read, memory ports take srcB from imm
        if (i < coreCfgPkg::numPcReads) begin : gInt
            assign pcRead[i] = '{valid: uops[i].valid, addr: uops[i].fetchID};
            assign rfReadAddr[i + coreCfgPkg::numUops] =
                uops[i].tagB[coreCfgPkg::regAddrBits-1:0];

            assign pc = {pcReadData[i].pc[30:coreCfgPkg::fetchOffBits], held.fetchOffs, 1'b0};
            assign startOffs = pcReadData[i].pc[coreCfgPkg::fetchOffBits-1:0];
            assign predOffs = pcReadData[i].branchPos;
            assign bpi = (held.fetchOffs == pcReadData[i].branchPos) ? pcReadData[i].bpi : '0;
        end else begin : gMem
            assign rfReadAddr[i + coreCfgPkg::numUops] = '0;

            assign pc = '0;
            assign startOffs = '0;
            assign predOffs = '0;
            assign bpi = '0;
        end

        always_comb begin
            nextUop = '0;
            nextUop.imm = uops[i].imm;
            nextUop.srcA = opA.value;
            nextIsReg = {1'b0, opA.fromRf};

            if (uops[i].immB || i >= coreCfgPkg::numPcReads) begin
                nextUop.srcB = uops[i].imm;
            end else begin
                nextUop.srcB = opB.value;
                nextIsReg[1] = opB.fromRf;
            end

            // JALR and JR carry their offset in imm12
            if (i < coreCfgPkg::numPcReads && uops[i].fu == uopPkg::FU_INT
                && (uops[i].opcode == uopPkg::INT_V_JALR
                    || uops[i].opcode == uopPkg::INT_V_JR)) begin
                nextUop.imm = {20'b0, uops[i].imm12};
            end

            nextUop.tagDst = uops[i].tagDst;
            nextUop.sqN = uops[i].sqN;
            nextUop.loadSqN = uops[i].loadSqN;
            nextUop.storeSqN = uops[i].storeSqN;
            nextUop.fetchID = uops[i].fetchID;
            nextUop.fetchOffs = uops[i].fetchOffs;
            nextUop.compressed = uops[i].compressed;
            nextUop.opcode = uops[i].opcode;
            nextUop.fu = uops[i].fu;
            nextUop.valid = 1'b1;
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                held.valid <= 1'b0;
                operandIsReg <= 2'b00;
                pcFresh <= 1'b0;
            end else if (accept) begin
                held <= nextUop;
                operandIsReg <= nextIsReg;
                pcFresh <= 1'b1;
            end else if (squashHeld || !stall[i]) begin
                held.valid <= 1'b0;
                operandIsReg <= 2'b00;
                pcFresh <= 1'b0;
            end else begin
                // First stalled cycle, the read ports move on after this
                if (operandIsReg[0]) begin
                    held.srcA <= rfReadData[i];
                end
                if (operandIsReg[1]) begin
                    held.srcB <= rfReadData[i + coreCfgPkg::numUops];
                end
                if (pcFresh) begin
                    held.pc <= pc;
                    held.fetchStartOffs <= startOffs;
                    held.fetchPredOffs <= predOffs;
                    held.bpi <= bpi;
                end
                operandIsReg <= 2'b00;
                pcFresh <= 1'b0;
            end
        end

        always_comb begin
            exUops[i] = held;
            if (operandIsReg[0]) begin
                exUops[i].srcA = rfReadData[i];
            end
            if (operandIsReg[1]) begin
                exUops[i].srcB = rfReadData[i + coreCfgPkg::numUops];
            end
            if (pcFresh) begin
                exUops[i].pc = pc;
                exUops[i].fetchStartOffs = startOffs;
                exUops[i].fetchPredOffs = predOffs;
                exUops[i].bpi = bpi;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/operandStage.sv
`timescale 1ns/1ps
`default_nettype none

module operandStage (
    input wire logic clk,
    input wire logic rst,

    input var uopPkg::IS_UOp issueUops [coreCfgPkg::numUops],
    input var uopPkg::RES_UOp wbResults [coreCfgPkg::numWbs],
    input var uopPkg::ZCForward zcFwds [coreCfgPkg::numZcFwds],

    input wire logic invalidate,
    input var uopPkg::SqN invalidateSqN,
    input wire logic [coreCfgPkg::numUops-1:0] stall,

    input var coreCfgPkg::PcFileWrite pcWrite,

    output uopPkg::EX_UOp exUops [coreCfgPkg::numUops]
);

    logic [coreCfgPkg::regAddrBits-1:0] rfReadAddr [2*coreCfgPkg::numUops];
    logic [31:0] rfReadData [2*coreCfgPkg::numUops];

    logic rfWrEn [coreCfgPkg::numWbs];
    logic [coreCfgPkg::regAddrBits-1:0] rfWrAddr [coreCfgPkg::numWbs];
    logic [31:0] rfWrData [coreCfgPkg::numWbs];

    coreCfgPkg::PcFileReadReq pcRead [coreCfgPkg::numPcReads];
    coreCfgPkg::FetchId pcReadAddr [coreCfgPkg::numPcReads];
    coreCfgPkg::PcFileEntry pcReadData [coreCfgPkg::numPcReads];

    logic pcWrEn [1];
    coreCfgPkg::FetchId pcWrAddr [1];
    coreCfgPkg::PcFileEntry pcWrData [1];

    // Constant destination tags never reach the register file
    for (genvar j = 0; j < coreCfgPkg::numWbs; j++) begin : gWb
        assign rfWrEn[j] = wbResults[j].valid && !wbResults[j].tagDst[6];
        assign rfWrAddr[j] = wbResults[j].tagDst[coreCfgPkg::regAddrBits-1:0];
        assign rfWrData[j] = wbResults[j].result;
    end

    for (genvar k = 0; k < coreCfgPkg::numPcReads; k++) begin : gPcRd
        assign pcReadAddr[k] = pcRead[k].addr;
    end

    assign pcWrEn[0] = pcWrite.valid;
    assign pcWrAddr[0] = pcWrite.addr;
    assign pcWrData[0] = pcWrite.data;

    operandLoad opLoad (
        .clk(clk),
        .rst(rst),
        .uops(issueUops),
        .wbResults(wbResults),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .stall(stall),
        .zcFwds(zcFwds),
        .pcRead(pcRead),
        .pcReadData(pcReadData),
        .rfReadAddr(rfReadAddr),
        .rfReadData(rfReadData),
        .exUops(exUops)
    );

    syncReadMem #(
        .entryType(logic [31:0]),
        .depth(coreCfgPkg::numRegs),
        .numReads(2 * coreCfgPkg::numUops),
        .numWrites(coreCfgPkg::numWbs)
    ) regFile (
        .clk(clk),
        .rdAddr(rfReadAddr),
        .rdData(rfReadData),
        .wrEn(rfWrEn),
        .wrAddr(rfWrAddr),
        .wrData(rfWrData)
    );

    syncReadMem #(
        .entryType(coreCfgPkg::PcFileEntry),
        .depth(coreCfgPkg::numFetchIds),
        .numReads(coreCfgPkg::numPcReads),
        .numWrites(1)
    ) pcFile (
        .clk(clk),
        .rdAddr(pcReadAddr),
        .rdData(pcReadData),
        .wrEn(pcWrEn),
        .wrAddr(pcWrAddr),
        .wrData(pcWrData)
    );

endmodule

`default_nettype wire

//--- rtl/syncReadMem.sv
`timescale 1ns/1ps
`default_nettype none

module syncReadMem #(
    parameter type entryType = logic [31:0],
    parameter int depth = 64,
    parameter int numReads = 1,
    parameter int numWrites = 1
) (
    input wire logic clk,

    input wire logic [$clog2(depth)-1:0] rdAddr [numReads],
    output entryType rdData [numReads],

    input wire logic wrEn [numWrites],
    input wire logic [$clog2(depth)-1:0] wrAddr [numWrites],
    input var entryType wrData [numWrites]
);

    entryType mem [depth];

    // Later write ports override earlier ones on the same entry
    always_ff @(posedge clk) begin
        for (int w = 0; w < numWrites; w++) begin
            if (wrEn[w]) begin
                mem[wrAddr[w]] <= wrData[w];
            end
        end
    end

    // Reads see the contents from before this edge's writes
    always_ff @(posedge clk) begin
        for (int r = 0; r < numReads; r++) begin
            rdData[r] <= mem[rdAddr[r]];
        end
    end

endmodule

`default_nettype wire

//--- rtl/uopPkg.sv
`default_nettype none

package uopPkg;

    // Age is taken from the signed difference of two sequence numbers
    typedef logic [6:0] SqN;

    // Bit 6 set means the low six bits are a constant
    typedef logic [6:0] Tag;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_MUL
    } FuncUnit;

    typedef enum logic [3:0] {
        INT_ADD,
        INT_SUB,
        INT_XOR,
        INT_OR,
        INT_AND,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_SLT,
        INT_SLTU,
        INT_LUI,
        INT_AUIPC,
        INT_JAL,
        INT_V_JALR,
        INT_V_JR,
        INT_SYS
    } IntOp;

    typedef struct packed {
        logic [31:0] imm;
        logic [11:0] imm12;
        Tag tagA;
        Tag tagB;
        Tag tagDst;
        logic immB;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        coreCfgPkg::FetchId fetchID;
        coreCfgPkg::FetchOff fetchOffs;
        logic compressed;
        IntOp opcode;
        FuncUnit fu;
        logic valid;
    } IS_UOp;

    // Operands resolved, ready for the execution units
    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [31:0] pc;
        coreCfgPkg::FetchOff fetchStartOffs;
        coreCfgPkg::FetchOff fetchPredOffs;
        coreCfgPkg::BranchPredInfo bpi;
        Tag tagDst;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        coreCfgPkg::FetchId fetchID;
        coreCfgPkg::FetchOff fetchOffs;
        logic compressed;
        IntOp opcode;
        FuncUnit fu;
        logic valid;
    } EX_UOp;

    typedef struct packed {
        logic [31:0] result;
        Tag tagDst;
        logic valid;
    } RES_UOp;

    typedef struct packed {
        logic valid;
        Tag tag;
        logic [31:0] result;
    } ZCForward;

endpackage

`default_nettype wire

//--- test/operandStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module operandStageTb;

    localparam int numRows = 13;
    localparam int preloadCycles = coreCfgPkg::numRegs / coreCfgPkg::numWbs;
    localparam int cycleLimit = numRows * 8 + preloadCycles + 50;

    typedef enum logic [2:0] {
        K_PLAIN,
        K_WB,
        K_ZC,
        K_STALL,
        K_SQUASH,
        K_SQUASH_HELD
    } Kind;

    typedef struct packed {
        logic [1:0] port;
        Kind kind;
        logic constTags;
        logic immB;
        uopPkg::IntOp opcode;
        logic matchBranch;
        logic squashNewer;
    } TestRow;

    TestRow rows [numRows] = '{
        '{2'd0, K_PLAIN, 1'b1, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd1, K_PLAIN, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd0, K_WB, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd1, K_ZC, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd2, K_PLAIN, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd3, K_PLAIN, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd1, K_PLAIN, 1'b0, 1'b1, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd0, K_PLAIN, 1'b0, 1'b0, uopPkg::INT_V_JALR, 1'b0, 1'b0},
        '{2'd1, K_PLAIN, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b1, 1'b0},
        '{2'd0, K_STALL, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd1, K_SQUASH, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b1},
        '{2'd0, K_SQUASH, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0},
        '{2'd3, K_SQUASH_HELD, 1'b0, 1'b0, uopPkg::INT_ADD, 1'b0, 1'b0}
    };
    string rowNames [numRows] = '{
        "constTags", "regTags", "wbBypass", "zcOverride", "memImm2", "memImm3",
        "immB", "jalrImm12", "bpiMatch", "stallHold", "squashNew", "squashOld",
        "squashHeld"
    };

    logic clk;
    logic rst;
    uopPkg::IS_UOp issueUops [coreCfgPkg::numUops];
    uopPkg::RES_UOp wbResults [coreCfgPkg::numWbs];
    uopPkg::ZCForward zcFwds [coreCfgPkg::numZcFwds];
    logic invalidate;
    uopPkg::SqN invalidateSqN;
    logic [coreCfgPkg::numUops-1:0] stall;
    coreCfgPkg::PcFileWrite pcWrite;
    uopPkg::EX_UOp exUops [coreCfgPkg::numUops];

    // Shadow copies of the register file and PC file
    logic [31:0] regShadow [coreCfgPkg::numRegs];
    coreCfgPkg::PcFileEntry pcShadow [coreCfgPkg::numFetchIds];

    logic [31:0] lfsrState = 32'ha3430a76;
    uopPkg::SqN seqNum = '0;
    int cycleCount = 0;

    operandStage UUT (
        .clk(clk),
        .rst(rst),
        .issueUops(issueUops),
        .wbResults(wbResults),
        .zcFwds(zcFwds),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .stall(stall),
        .pcWrite(pcWrite),
        .exUops(exUops)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("TB FAILED");
            $fatal(1, "Run did not finish within %0d cycles", cycleLimit);
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            val = {val[30:0], lfsrState[0]};
            if (lfsrState[0]) begin
                lfsrState = (lfsrState >> 1) ^ 32'hD000_0001;
            end else begin
                lfsrState = lfsrState >> 1;
            end
        end
        return val;
    endfunction

    function automatic uopPkg::Tag randTag(input logic isConst);
        logic [31:0] bits;
        bits = randBits(6);
        return {isConst, bits[5:0]};
    endfunction

    function automatic uopPkg::IS_UOp makeUop(input TestRow row);
        uopPkg::IS_UOp u;
        u = '0;
        u.valid = 1'b1;
        u.tagA = randTag(row.constTags);
        u.tagB = randTag(row.constTags);
        u.tagDst = randTag(1'b0);
        u.immB = row.immB;
        u.imm = randBits(32);
        u.imm12 = 12'(randBits(12));
        u.sqN = seqNum;
        seqNum = seqNum + 7'd4;
        u.loadSqN = uopPkg::SqN'(randBits(7));
        u.storeSqN = uopPkg::SqN'(randBits(7));
        u.compressed = 1'(randBits(1));
        u.fetchID = coreCfgPkg::FetchId'(randBits(4));
        u.fetchOffs = row.matchBranch ? pcShadow[u.fetchID].branchPos : 3'(randBits(3));
        u.opcode = row.opcode;
        u.fu = (row.port >= 2'd2) ? uopPkg::FU_LSU : uopPkg::FU_INT;
        return u;
    endfunction

    // Constant, then zero-cycle forward, then writeback, then register value
    function automatic logic [31:0] expectOperand(input uopPkg::Tag tag);
        logic [31:0] val;
        if (tag[6]) begin
            return {{26{tag[5]}}, tag[5:0]};
        end
        val = regShadow[tag[5:0]];
        for (int j = 0; j < coreCfgPkg::numWbs; j++) begin
            if (wbResults[j].valid && wbResults[j].tagDst == tag) begin
                val = wbResults[j].result;
            end
        end
        if (zcFwds[0].valid && zcFwds[0].tag == tag) begin
            val = zcFwds[0].result;
        end
        return val;
    endfunction

    function automatic uopPkg::EX_UOp expectUop(input logic [1:0] port, input uopPkg::IS_UOp u);
        uopPkg::EX_UOp e;
        coreCfgPkg::PcFileEntry entry;
        e = '0;
        e.valid = 1'b1;
        e.sqN = u.sqN;
        e.tagDst = u.tagDst;
        e.loadSqN = u.loadSqN;
        e.storeSqN = u.storeSqN;
        e.fetchID = u.fetchID;
        e.fetchOffs = u.fetchOffs;
        e.compressed = u.compressed;
        e.opcode = u.opcode;
        e.fu = u.fu;
        e.srcA = expectOperand(u.tagA);
        e.srcB = (u.immB || port >= 2'd2) ? u.imm : expectOperand(u.tagB);
        e.imm = u.imm;
        if (port < 2'd2) begin
            if (u.fu == uopPkg::FU_INT
                && (u.opcode == uopPkg::INT_V_JALR || u.opcode == uopPkg::INT_V_JR)) begin
                e.imm = {20'b0, u.imm12};
            end
            entry = pcShadow[u.fetchID];
            e.pc = {entry.pc[30:3], u.fetchOffs, 1'b0};
            e.fetchStartOffs = entry.pc[2:0];
            e.fetchPredOffs = entry.branchPos;
            e.bpi = (u.fetchOffs == entry.branchPos) ? entry.bpi : '0;
        end
        return e;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic checkUop(input string name, input logic [1:0] port,
            input uopPkg::EX_UOp e, input logic full);
        uopPkg::EX_UOp a;
        a = exUops[port];
        checkValue({name, " valid"}, 32'(e.valid), 32'(a.valid));
        if (e.valid) begin
            checkValue({name, " srcA"}, e.srcA, a.srcA);
            checkValue({name, " srcB"}, e.srcB, a.srcB);
            checkValue({name, " sqN"}, 32'(e.sqN), 32'(a.sqN));
            if (full) begin
                checkValue({name, " imm"}, e.imm, a.imm);
                checkValue({name, " pc"}, e.pc, a.pc);
                checkValue({name, " startOffs"}, 32'(e.fetchStartOffs), 32'(a.fetchStartOffs));
                checkValue({name, " predOffs"}, 32'(e.fetchPredOffs), 32'(a.fetchPredOffs));
                checkValue({name, " bpi"}, 32'(e.bpi), 32'(a.bpi));
                checkValue({name, " dstSqNs"}, 32'({e.tagDst, e.loadSqN, e.storeSqN}),
                    32'({a.tagDst, a.loadSqN, a.storeSqN}));
                checkValue({name, " fetchOp"},
                    32'({e.fetchID, e.fetchOffs, e.compressed, e.opcode, e.fu}),
                    32'({a.fetchID, a.fetchOffs, a.compressed, a.opcode, a.fu}));
            end
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clearInputs();
        for (int i = 0; i < coreCfgPkg::numUops; i++) begin
            issueUops[i] = '0;
        end
        for (int j = 0; j < coreCfgPkg::numWbs; j++) begin
            wbResults[j] = '0;
        end
        zcFwds[0] = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        stall = '0;
        pcWrite = '0;
    endtask

    // Fill every register through the writeback buses and every PC entry
    task automatic preload();
        coreCfgPkg::PcFileEntry entry;
        for (int c = 0; c < preloadCycles; c++) begin
            for (int j = 0; j < coreCfgPkg::numWbs; j++) begin
                regShadow[c * coreCfgPkg::numWbs + j] = randBits(32);
                wbResults[j].result = regShadow[c * coreCfgPkg::numWbs + j];
                wbResults[j].tagDst = 7'(c * coreCfgPkg::numWbs + j);
                wbResults[j].valid = 1'b1;
            end
            pcWrite = '0;
            if (c < coreCfgPkg::numFetchIds) begin
                entry.pc = 31'(randBits(31));
                entry.branchPos = 3'(randBits(3));
                entry.bpi.predicted = 1'b1;
                entry.bpi.taken = 1'(randBits(1));
                pcShadow[c] = entry;
                pcWrite.valid = 1'b1;
                pcWrite.addr = coreCfgPkg::FetchId'(c);
                pcWrite.data = entry;
            end
            nextCycle();
        end
        clearInputs();
    endtask

    task automatic runRow(input int r);
        TestRow row;
        uopPkg::IS_UOp u;
        uopPkg::EX_UOp e;
        uopPkg::EX_UOp eNext;
        string name;
        row = rows[r];
        name = rowNames[r];
        u = makeUop(row);
        issueUops[row.port] = u;
        if (row.kind == K_WB || row.kind == K_ZC) begin
            wbResults[1] = '{result: randBits(32), tagDst: u.tagA, valid: 1'b1};
        end
        if (row.kind == K_ZC) begin
            zcFwds[0] = '{valid: 1'b1, tag: u.tagA, result: randBits(32)};
        end
        if (row.kind == K_SQUASH) begin
            invalidate = 1'b1;
            invalidateSqN = row.squashNewer ? u.sqN - 7'd2 : u.sqN + 7'd2;
        end
        e = expectUop(row.port, u);
        if (row.kind == K_SQUASH && row.squashNewer) begin
            e = '0;
        end
        if (wbResults[1].valid) begin
            regShadow[wbResults[1].tagDst[5:0]] = wbResults[1].result;
        end
        nextCycle();
        issueUops[row.port] = '0;
        wbResults[1] = '0;
        zcFwds[0] = '0;
        invalidate = 1'b0;
        checkUop(name, row.port, e, 1'b1);

        if (row.kind == K_STALL) begin
            stall[row.port] = 1'b1;
            u = makeUop(row);
            issueUops[row.port] = u;
            eNext = expectUop(row.port, u);
            repeat (3) begin
                nextCycle();
                checkUop({name, " held"}, row.port, e, 1'b1);
            end
            stall[row.port] = 1'b0;
            nextCycle();
            issueUops[row.port] = '0;
            checkUop({name, " next"}, row.port, eNext, 1'b1);
        end

        if (row.kind == K_SQUASH_HELD) begin
            stall[row.port] = 1'b1;
            nextCycle();
            checkUop({name, " held"}, row.port, e, 1'b1);
            invalidate = 1'b1;
            invalidateSqN = e.sqN - 7'd1;
            nextCycle();
            invalidate = 1'b0;
            stall[row.port] = 1'b0;
            checkUop({name, " squashed"}, row.port, '0, 1'b0);
        end

        // Output clears once nothing new is issued
        nextCycle();
        checkUop({name, " clear"}, row.port, '0, 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        clearInputs();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        preload();
        for (int r = 0; r < numRows; r++) begin
            runRow(r);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/operandStage_props.sv
`timescale 1ns/1ps
`default_nettype none

module operandStage_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic invalidate,
    input var uopPkg::SqN invalidateSqN,
    input wire logic [coreCfgPkg::numUops-1:0] stall,
    input var uopPkg::EX_UOp exUops [coreCfgPkg::numUops]
);

    // Newer when the difference is positive as a signed number
    function automatic logic newerThan(input uopPkg::SqN a, input uopPkg::SqN b);
        uopPkg::SqN diff;
        diff = a - b;
        return diff != '0 && !diff[6];
    endfunction

    for (genvar i = 0; i < coreCfgPkg::numUops; i++) begin : gPort
        assert property (@(posedge clk) rst |=> !exUops[i].valid)
            else $error("exUops[%0d] valid in the cycle after reset", i);

        assert property (@(posedge clk) disable iff (rst)
            stall[i] && exUops[i].valid && !invalidate |=> exUops[i].sqN == $past(exUops[i].sqN))
            else $error("exUops[%0d] changed while stalled", i);

        assert property (@(posedge clk) disable iff (rst)
            invalidate |=> !(exUops[i].valid && newerThan(exUops[i].sqN, $past(invalidateSqN))))
            else $error("exUops[%0d] squashed uop still valid", i);
    end

endmodule

bind operandStage operandStage_props props (
    .clk(clk),
    .rst(rst),
    .invalidate(invalidate),
    .invalidateSqN(invalidateSqN),
    .stall(stall),
    .exUops(exUops)
);

`default_nettype wire

//--- vlog.f
rtl/coreCfgPkg.sv
rtl/uopPkg.sv
rtl/syncReadMem.sv
rtl/operandLoad.sv
rtl/operandStage.sv
test/operandStage_props.sv
test/operandStageTb.sv
